// File: testbench/cpu_golden.txt
// kind word_address data: P = word written before run, E = word expected after halt
// Text after the data column is a note only
P 00 24010007 addiu r1, r0, 7
P 01 2402fff7 addiu r2, r0, -9
P 02 00221821 addu r3, r1, r2
P 03 ac030200 sw r3, 0x200(r0)
P 04 00222023 subu r4, r1, r2
P 05 ac040204 sw r4, 0x204(r0)
P 06 3c051234 lui r5, 0x1234
P 07 34a55678 ori r5, r5, 0x5678
P 08 ac050208 sw r5, 0x208(r0)
P 09 00a23024 and r6, r5, r2
P 0a ac06020c sw r6, 0x20c(r0)
P 0b 00253825 or r7, r1, r5
P 0c ac070210 sw r7, 0x210(r0)
P 0d 0041402a slt r8, r2, r1
P 0e ac080214 sw r8, 0x214(r0)
P 0f 0022482a slt r9, r1, r2
P 10 ac090218 sw r9, 0x218(r0)
P 11 00255004 sllv r10, r5, r1
P 12 ac0a021c sw r10, 0x21c(r0)
P 13 240b0001 addiu r11, r0, 1
P 14 016b5821 addu r11, r11, r11
P 15 016b5821 addu r11, r11, r11
P 16 256b0100 addiu r11, r11, 0x100
P 17 ac0b0220 sw r11, 0x220(r0)
P 18 8c0c0208 lw r12, 0x208(r0)
P 19 258d0001 addiu r13, r12, 1
P 1a ac0d0224 sw r13, 0x224(r0)
P 1b 10210001 beq r1, r1, +1
P 1c ac000240 sw r0, 0x240(r0) skipped
P 1d 14210001 bne r1, r1, +1
P 1e 240e0055 addiu r14, r0, 0x55
P 1f ac0e0228 sw r14, 0x228(r0)
P 20 08000022 j 0x22
P 21 ac000244 sw r0, 0x244(r0) skipped
P 22 0c000026 jal 0x26
P 23 ac1f022c sw r31, 0x22c(r0)
P 24 fc000000 halt
P 25 ac000248 sw r0, 0x248(r0) after halt
P 26 03e00008 jr r31
P 27 ac00024c sw r0, 0x24c(r0) skipped
P 90 dead0090 marker
P 91 dead0091 marker
P 92 dead0092 marker
P 93 dead0093 marker
E 80 fffffffe addu 7 + -9
E 81 00000010 subu 7 - -9
E 82 12345678 lui then ori
E 83 12345670 and
E 84 1234567f or
E 85 00000001 slt -9 < 7
E 86 00000000 slt 7 < -9
E 87 1a2b3c00 sllv by 7
E 88 00000104 dependence chain
E 89 12345679 load then use
E 8a 00000055 bne falls through
E 8b 0000008c link address
E 90 dead0090
E 91 dead0091
E 92 dead0092
E 93 dead0093

// File: compile.f
+incdir+src
src/cpu_types_pkg.sv
src/mem_bus_if.sv
src/register_file.sv
src/control_unit.sv
src/alu.sv
src/datapath.sv
src/memory_arbiter.sv
src/ram.sv
src/cpu_top.sv
testbench/cpu_tb.sv

// File: Bender.yml
package:
  name: pipelined_cpu

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/cpu_types_pkg.sv
      - src/mem_bus_if.sv
      - src/register_file.sv
      - src/control_unit.sv
      - src/alu.sv
      - src/datapath.sv
      - src/memory_arbiter.sv
      - src/ram.sv
      - src/cpu_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - testbench/cpu_tb.sv

// File: testbench/cpu_tb.sv
/*
  Testbench for cpu_top. Reads testbench/cpu_golden.txt, so run it from the
  project root. P records are written through the host port with run low,
  then the core runs to halt and every E record is read back and compared.
  A spare word and a guard word outside the program and result areas are
  also checked.
*/
`timescale 1ns/1ns
`default_nettype none
`include "cpu_settings.svh"

module cpu_tb import cpu_types_pkg::*; ();
    localparam word_t SPARE_ADDR = 32'h0000_00f0;
    localparam word_t GUARD_ADDR = 32'h0000_00a0;

    logic  CLK;
    logic  reset;
    logic  run;
    logic  host_ren;
    logic  host_wen;
    word_t host_addr;
    word_t host_wdata;
    word_t host_rdata;
    logic  host_hit;
    logic  halt;

    word_t prog_addr[$];
    word_t prog_data[$];
    word_t exp_addr[$];
    word_t exp_data[$];
    int    errors;
    int    checks;
    int    cycles;
    int    limit;

    cpu_top cpu_top_inst (
        .CLK       (CLK),
        .reset     (reset),
        .run       (run),
        .host_ren  (host_ren),
        .host_wen  (host_wen),
        .host_addr (host_addr),
        .host_wdata(host_wdata),
        .host_rdata(host_rdata),
        .host_hit  (host_hit),
        .halt      (halt)
    );

    initial begin
        CLK = 1'b0;
        forever begin
            #10 CLK = ~CLK;
        end
    end

    // Cycle limit is set once the golden file has been read
    initial begin
        cycles = 0;
        while (limit == 0 || cycles < limit) begin
            @(posedge CLK);
            cycles++;
        end
        $display("Timeout after %0d cycles, the run did not complete", cycles);
        $display("Some tests failed");
        $finish;
    end

    function automatic int unsigned lcg_next(input int unsigned state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic read_golden(output bit ok);
        int         fd;
        int         n;
        string      line;
        logic [7:0] kind;
        word_t      addr;
        word_t      data;
        ok = 1'b0;
        fd = $fopen("testbench/cpu_golden.txt", "r");
        if (fd == 0) begin
            $display("Cannot open testbench/cpu_golden.txt for reading");
            return;
        end
        while ($fgets(line, fd) != 0) begin
            // Comment and blank lines fail the three conversions
            n = $sscanf(line, "%c %h %h", kind, addr, data);
            if (n == 3 && kind == "P") begin
                prog_addr.push_back(addr);
                prog_data.push_back(data);
            end else if (n == 3 && kind == "E") begin
                exp_addr.push_back(addr);
                exp_data.push_back(data);
            end
        end
        $fclose(fd);
        ok = (prog_addr.size() > 0) && (exp_addr.size() > 0);
        if (!ok) begin
            $display("The golden file holds no program words or no expected words");
        end
    endtask

    // Starts 2 ns after a rising edge and returns at the same point
    task automatic host_access(input logic write, input word_t word_addr,
                               input word_t wdata, output word_t rdata);
        host_ren   = !write;
        host_wen   = write;
        host_addr  = word_addr << 2;
        host_wdata = wdata;
        @(negedge CLK);
        while (!host_hit) begin
            @(negedge CLK);
        end
        rdata = host_rdata;
        @(posedge CLK);
        #2;
        host_ren = 1'b0;
        host_wen = 1'b0;
    endtask

    task automatic check_word(input word_t addr, input word_t expected, input word_t got);
        checks++;
        assert (got == expected) else begin
            errors++;
            $display("Error at %0t ns: word %h expected %h, read %h",
                     $time, addr, expected, got);
        end
    endtask

    initial begin
        bit          loaded;
        word_t       got;
        word_t       spare_word;
        word_t       guard_word;
        int unsigned rand_state;
        reset      = 1'b1;
        run        = 1'b0;
        host_ren   = 1'b0;
        host_wen   = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        errors     = 0;
        checks     = 0;
        limit      = 0;
        read_golden(loaded);
        if (!loaded) begin
            errors++;
        end else begin
            limit = (prog_addr.size() + exp_addr.size()) * (`CPU_RAM_LATENCY + 2) + 400;
            rand_state = lcg_next(32'd73);
            spare_word = rand_state;
            rand_state = lcg_next(rand_state);
            guard_word = rand_state;
            repeat (5) @(posedge CLK);
            #2;
            reset = 1'b0;

            // Host path on its own while the core is idle
            host_access(1'b1, SPARE_ADDR, spare_word, got);
            host_access(1'b0, SPARE_ADDR, '0, got);
            check_word(SPARE_ADDR, spare_word, got);
            host_access(1'b1, GUARD_ADDR, guard_word, got);

            foreach (prog_addr[i]) begin
                host_access(1'b1, prog_addr[i], prog_data[i], got);
            end

            run = 1'b1;
            while (!halt) begin
                @(negedge CLK);
            end
            @(posedge CLK);
            #2;

            foreach (exp_addr[i]) begin
                host_access(1'b0, exp_addr[i], '0, got);
                check_word(exp_addr[i], exp_data[i], got);
            end
            host_access(1'b0, GUARD_ADDR, '0, got);
            check_word(GUARD_ADDR, guard_word, got);
            host_access(1'b0, SPARE_ADDR, '0, got);
            check_word(SPARE_ADDR, spare_word, got);

            checks++;
            assert (halt) else begin
                errors++;
                $display("halt went low again after the program finished");
            end
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src/cpu_top.sv
/*
  Processor top level. The host port shares the RAM at the highest
  priority and should load the program while run is low.
*/
`timescale 1ns/1ns
`default_nettype none

module cpu_top import cpu_types_pkg::*; (
    input  logic  CLK,
    input  logic  reset,
    input  logic  run,
    input  logic  host_ren,
    input  logic  host_wen,
    input  word_t host_addr,
    input  word_t host_wdata,
    output word_t host_rdata,
    output logic  host_hit,
    output logic  halt
);
    mem_bus_if host_bus ();
    mem_bus_if imem_bus ();
    mem_bus_if dmem_bus ();
    mem_bus_if ram_bus ();

    assign host_bus.ren   = host_ren;
    assign host_bus.wen   = host_wen;
    assign host_bus.addr  = host_addr;
    assign host_bus.wdata = host_wdata;
    assign host_rdata     = host_bus.rdata;
    assign host_hit       = host_bus.hit;

    datapath datapath_inst (
        .CLK  (CLK),
        .reset(reset),
        .run  (run),
        .imem (imem_bus.requester),
        .dmem (dmem_bus.requester),
        .halt (halt)
    );

    memory_arbiter memory_arbiter_inst (
        .CLK  (CLK),
        .reset(reset),
        .host (host_bus.server),
        .data (dmem_bus.server),
        .fetch(imem_bus.server),
        .ram  (ram_bus.requester)
    );

    ram ram_inst (
        .CLK  (CLK),
        .reset(reset),
        .bus  (ram_bus.server)
    );

endmodule

`default_nettype wire

// File: src/ram.sv
/*
  Single-port word memory with a fixed latency. Address bits above the
  depth are ignored and the two low bits select nothing. Contents are
  not cleared by reset. A write lands at the hit.
*/
`timescale 1ns/1ns
`default_nettype none
`include "cpu_settings.svh"

module ram import cpu_types_pkg::*; (
    input  logic      CLK,
    input  logic      reset,
    mem_bus_if.server bus
);
    localparam int IDX_W = $clog2(`CPU_MEM_WORDS);
    localparam int CNT_W = $clog2(`CPU_RAM_LATENCY + 1);

    word_t            mem [`CPU_MEM_WORDS];
    logic [IDX_W-1:0] index;
    logic [CNT_W-1:0] count;
    logic             req;

    assign req       = bus.ren || bus.wen;
    assign index     = bus.addr[IDX_W+1:2];
    assign bus.hit   = req && (count == CNT_W'(`CPU_RAM_LATENCY));
    assign bus.rdata = mem[index];

    // Counter restarts after each hit, so a held request is a new access
    always_ff @(posedge CLK) begin
        if (reset) begin
            count <= '0;
        end else if (req && !bus.hit) begin
            count <= count + 1'b1;
        end else begin
            count <= '0;
        end
    end

    always_ff @(posedge CLK) begin
        if (bus.wen && bus.hit) begin
            mem[index] <= bus.wdata;
        end
    end

endmodule

`default_nettype wire

// File: src/memory_arbiter.sv
/*
  Fixed priority: host, then data, then fetch. A grant is taken in idle
  and held until the RAM hit, then the arbiter returns to idle for one
  cycle. Waiting requesters must hold their requests.
*/
`timescale 1ns/1ns
`default_nettype none

module memory_arbiter import cpu_types_pkg::*; (
    input  logic         CLK,
    input  logic         reset,
    mem_bus_if.server    host,
    mem_bus_if.server    data,
    mem_bus_if.server    fetch,
    mem_bus_if.requester ram
);
    arb_state_t state;

    always_ff @(posedge CLK) begin
        if (reset) begin
            state <= ARB_IDLE;
        end else if (state == ARB_IDLE) begin
            if (host.ren || host.wen) begin
                state <= ARB_HOST;
            end else if (data.ren || data.wen) begin
                state <= ARB_DATA;
            end else if (fetch.ren || fetch.wen) begin
                state <= ARB_FETCH;
            end
        end else if (ram.hit) begin
            state <= ARB_IDLE;
        end
    end

    // Route the granted port; others see neither data nor hit
    always_comb begin
        ram.ren     = 1'b0;
        ram.wen     = 1'b0;
        ram.addr    = fetch.addr;
        ram.wdata   = fetch.wdata;
        host.rdata  = '0;
        host.hit    = 1'b0;
        data.rdata  = '0;
        data.hit    = 1'b0;
        fetch.rdata = '0;
        fetch.hit   = 1'b0;
        case (state)
            ARB_HOST: begin
                ram.ren    = host.ren;
                ram.wen    = host.wen;
                ram.addr   = host.addr;
                ram.wdata  = host.wdata;
                host.rdata = ram.rdata;
                host.hit   = ram.hit;
            end
            ARB_DATA: begin
                ram.ren    = data.ren;
                ram.wen    = data.wen;
                ram.addr   = data.addr;
                ram.wdata  = data.wdata;
                data.rdata = ram.rdata;
                data.hit   = ram.hit;
            end
            ARB_FETCH: begin
                ram.ren     = fetch.ren;
                ram.wen     = fetch.wen;
                fetch.rdata = ram.rdata;
                fetch.hit   = ram.hit;
            end
            default: ram.ren = 1'b0;
        endcase
    end

    a_one_hit : assert property (@(posedge CLK) disable iff (reset)
        $onehot0({host.hit, data.hit, fetch.hit}))
        else $error("memory_arbiter: hit routed to more than one requester");

endmodule

`default_nettype wire

// File: src/datapath.sv
/*
  Five-stage pipeline without forwarding. Decode stalls while EX or MEM
  holds a writer of one of its source registers; WB reaches decode through
  the register file write-through. Branches resolve in decode with no
  delay slot. run must stay high once raised. Fetch stops when HALT leaves
  decode and halt stays high until reset.
*/
`timescale 1ns/1ns
`default_nettype none
`include "cpu_settings.svh"

module datapath import cpu_types_pkg::*; (
    input  logic         CLK,
    input  logic         reset,
    input  logic         run,
    mem_bus_if.requester imem,
    mem_bus_if.requester dmem,
    output logic         halt
);
    typedef struct packed {
        word_t instr;
        word_t pc4;
    } if_id_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    rdat1;
        word_t    rdat2;
        word_t    imm;
        regbits_t wsel;
        word_t    pc4;
    } id_ex_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    alu_out;
        word_t    store;
        regbits_t wsel;
        word_t    pc4;
    } ex_mem_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    alu_out;
        word_t    load;
        regbits_t wsel;
        word_t    pc4;
    } mem_wb_t;

    if_id_t   if_id;
    id_ex_t   id_ex;
    ex_mem_t  ex_mem;
    mem_wb_t  mem_wb;
    word_t    pc, pc4, fetched, if_buf, mem_buf;
    logic     fetch_req, fetch_stop, if_done, mem_done;
    logic     if_ok, mem_ok, advance, take_fetch, stall, taken;
    logic     rs_busy, rt_busy;
    regbits_t rs, rt, rd, id_wsel;
    ctrl_t    id_ctrl;
    word_t    rdat1, rdat2, id_imm, target;
    word_t    alu_b, alu_out, wb_data;

    // Fetch; a completed word waits in if_buf while the pipe holds
    assign fetch_req   = run && !fetch_stop;
    assign imem.ren    = fetch_req && !if_done;
    assign imem.wen    = 1'b0;
    assign imem.addr   = pc;
    assign imem.wdata  = '0;
    assign pc4         = pc + 32'd4;
    assign fetched     = if_done ? if_buf : imem.rdata;

    // Pipe moves as one when fetch and data access are both satisfied
    assign if_ok      = stall || !fetch_req || if_done || imem.hit;
    assign mem_ok     = !(ex_mem.ctrl.mem_ren || ex_mem.ctrl.mem_wen) || mem_done || dmem.hit;
    assign advance    = if_ok && mem_ok;
    assign take_fetch = advance && !stall && fetch_req;

    // Decode
    assign rs = if_id.instr[25:21];
    assign rt = if_id.instr[20:16];
    assign rd = if_id.instr[15:11];

    control_unit control_unit_inst (
        .opcode(opcode_t'(if_id.instr[31:26])),
        .funct (funct_t'(if_id.instr[5:0])),
        .ctrl  (id_ctrl)
    );

    register_file register_file_inst (
        .CLK  (CLK),
        .reset(reset),
        .wen  (mem_wb.ctrl.reg_wen),
        .wsel (mem_wb.wsel),
        .wdat (wb_data),
        .rsel1(rs),
        .rsel2(rt),
        .rdat1(rdat1),
        .rdat2(rdat2)
    );

    assign id_imm = id_ctrl.zero_ext ? {16'b0, if_id.instr[15:0]}
                                     : {{16{if_id.instr[15]}}, if_id.instr[15:0]};

    always_comb begin
        case (id_ctrl.reg_dst)
            REG_DST_RD: id_wsel = rd;
            REG_DST_RA: id_wsel = 5'd31;
            default:    id_wsel = rt;
        endcase
    end

    assign taken = (id_ctrl.beq && rdat1 == rdat2) || (id_ctrl.bne && rdat1 != rdat2)
                 || id_ctrl.jump || id_ctrl.jr;
    assign target = id_ctrl.jr   ? rdat1 :
                    id_ctrl.jump ? {if_id.pc4[31:28], if_id.instr[25:0], 2'b00} :
                                   if_id.pc4 + (id_imm << 2);

    // Producers still in EX or MEM block decode
    assign rs_busy = (id_ex.ctrl.reg_wen && id_ex.wsel == rs)
                  || (ex_mem.ctrl.reg_wen && ex_mem.wsel == rs);
    assign rt_busy = (id_ex.ctrl.reg_wen && id_ex.wsel == rt)
                  || (ex_mem.ctrl.reg_wen && ex_mem.wsel == rt);
    assign stall   = (rs != '0 && rs_busy) || (rt != '0 && rt_busy);

    // Execute
    assign alu_b = id_ex.ctrl.alu_src ? id_ex.imm : id_ex.rdat2;

    alu alu_inst (
        .op    (id_ex.ctrl.alu_op),
        .port_a(id_ex.rdat1),
        .port_b(alu_b),
        .result(alu_out)
    );

    // Memory; request drops once hit until the pipe moves on
    assign dmem.ren   = ex_mem.ctrl.mem_ren && !mem_done;
    assign dmem.wen   = ex_mem.ctrl.mem_wen && !mem_done;
    assign dmem.addr  = ex_mem.alu_out;
    assign dmem.wdata = ex_mem.store;

    // Write-back
    assign wb_data = mem_wb.ctrl.jal        ? mem_wb.pc4 :
                     mem_wb.ctrl.mem_to_reg ? mem_wb.load : mem_wb.alu_out;

    always_ff @(posedge CLK) begin
        if (reset) begin
            pc         <= `CPU_PC_INIT;
            fetch_stop <= 1'b0;
            if_done    <= 1'b0;
            mem_done   <= 1'b0;
            halt       <= 1'b0;
        end else begin
            if (take_fetch) begin
                pc      <= taken ? target : pc4;
                if_done <= 1'b0;
                if (id_ctrl.halt) begin
                    fetch_stop <= 1'b1;
                end
            end else if (imem.hit) begin
                if_done <= 1'b1;
            end
            if (advance) begin
                mem_done <= 1'b0;
            end else if (dmem.hit) begin
                mem_done <= 1'b1;
            end
            if (mem_wb.ctrl.halt) begin
                halt <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (imem.hit) begin
            if_buf <= imem.rdata;
        end
        if (dmem.hit) begin
            mem_buf <= dmem.rdata;
        end
    end

    // Pipeline registers; reset and flushes load all-zero bubbles
    always_ff @(posedge CLK) begin
        if (reset) begin
            if_id  <= '0;
            id_ex  <= '0;
            ex_mem <= '0;
            mem_wb <= '0;
        end else if (advance) begin
            if (stall) begin
                id_ex <= '0;
            end else begin
                if_id <= (take_fetch && !taken && !id_ctrl.halt) ? '{fetched, pc4} : '0;
                id_ex <= '{ctrl: id_ctrl, rdat1: rdat1, rdat2: rdat2, imm: id_imm,
                           wsel: id_wsel, pc4: if_id.pc4};
            end
            ex_mem <= '{ctrl: id_ex.ctrl, alu_out: alu_out, store: id_ex.rdat2,
                        wsel: id_ex.wsel, pc4: id_ex.pc4};
            mem_wb <= '{ctrl: ex_mem.ctrl, alu_out: ex_mem.alu_out,
                        load: mem_done ? mem_buf : dmem.rdata,
                        wsel: ex_mem.wsel, pc4: ex_mem.pc4};
        end
    end

    a_no_rw : assert property (@(posedge CLK) disable iff (reset)
        !(imem.ren && imem.wen) && !(dmem.ren && dmem.wen))
        else $error("datapath: read and write requested together");

    a_pc_aligned : assert property (@(posedge CLK) disable iff (reset) pc[1:0] == 2'b00)
        else $error("datapath: PC %h not word aligned", pc);

endmodule

`default_nettype wire

// File: src/alu.sv
/*
  Combinational ALU. slt compares signed. sll shifts port_b by the low
  five bits of port_a, as SLLV takes rs as the shift amount.
*/
`timescale 1ns/1ns
`default_nettype none

module alu import cpu_types_pkg::*; (
    input  alu_op_t op,
    input  word_t   port_a,
    input  word_t   port_b,
    output word_t   result
);
    always_comb begin
        case (op)
            ALU_ADD: result = port_a + port_b;
            ALU_SUB: result = port_a - port_b;
            ALU_AND: result = port_a & port_b;
            ALU_OR:  result = port_a | port_b;
            ALU_SLT: result = word_t'($signed(port_a) < $signed(port_b));
            ALU_SLL: result = port_b << port_a[4:0];
            // Immediate lands in the upper half
            ALU_LUI: result = port_b << 16;
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: src/control_unit.sv
/*
  Maps opcode and funct to the decoded control fields.
  Encodings outside the subset decode as a no-op with every enable low.
*/
`timescale 1ns/1ns
`default_nettype none

module control_unit import cpu_types_pkg::*; (
    input  opcode_t opcode,
    input  funct_t  funct,
    output ctrl_t   ctrl
);
    always_comb begin
        ctrl = '0;
        case (opcode)
            RTYPE: begin
                ctrl.reg_dst = REG_DST_RD;
                ctrl.reg_wen = 1'b1;
                case (funct)
                    FN_ADDU: ctrl.alu_op = ALU_ADD;
                    FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    FN_SLLV: ctrl.alu_op = ALU_SLL;
                    FN_JR: begin
                        ctrl.reg_wen = 1'b0;
                        ctrl.jr      = 1'b1;
                    end
                    default: ctrl.reg_wen = 1'b0;
                endcase
            end
            ADDIU, ORI, LUI, LW: begin
                ctrl.alu_src  = 1'b1;
                ctrl.reg_wen  = 1'b1;
                ctrl.zero_ext = (opcode == ORI);
                ctrl.alu_op   = (opcode == ORI) ? ALU_OR : (opcode == LUI) ? ALU_LUI : ALU_ADD;
                ctrl.mem_ren    = (opcode == LW);
                ctrl.mem_to_reg = (opcode == LW);
            end
            SW: begin
                ctrl.alu_src = 1'b1;
                ctrl.mem_wen = 1'b1;
            end
            BEQ:  ctrl.beq = 1'b1;
            BNE:  ctrl.bne = 1'b1;
            J:    ctrl.jump = 1'b1;
            JAL: begin
                ctrl.jump    = 1'b1;
                ctrl.jal     = 1'b1;
                ctrl.reg_wen = 1'b1;
                ctrl.reg_dst = REG_DST_RA;
            end
            HALT: ctrl.halt = 1'b1;
            default: ctrl = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: src/register_file.sv
/*
  Two read ports and one write port. Register zero always reads zero.
  A read of the register being written returns the write data.
*/
`timescale 1ns/1ns
`default_nettype none
`include "cpu_settings.svh"

module register_file import cpu_types_pkg::*; (
    input  logic     CLK,
    input  logic     reset,
    input  logic     wen,
    input  regbits_t wsel,
    input  word_t    wdat,
    input  regbits_t rsel1,
    input  regbits_t rsel2,
    output word_t    rdat1,
    output word_t    rdat2
);
    word_t regs [`CPU_REG_COUNT];
    logic  write_ok;

    assign write_ok = wen && (wsel != '0);

    always_ff @(posedge CLK) begin
        if (reset) begin
            regs <= '{default: '0};
        end else if (write_ok) begin
            regs[wsel] <= wdat;
        end
    end

    // Write-through so WB results reach decode in the same cycle
    assign rdat1 = (write_ok && wsel == rsel1) ? wdat : regs[rsel1];
    assign rdat2 = (write_ok && wsel == rsel2) ? wdat : regs[rsel2];

    a_zero_reg : assert property (@(posedge CLK) disable iff (reset) regs[0] == '0)
        else $error("register_file: register zero holds %h", regs[0]);

endmodule

`default_nettype wire

// File: src/mem_bus_if.sv
/*
  One memory request/response channel. The requester holds ren or wen
  with a stable addr and wdata until hit. hit lasts one cycle and rdata
  is valid with it. ren and wen are never high together.
*/
`timescale 1ns/1ns
`default_nettype none

interface mem_bus_if import cpu_types_pkg::*; ();
    logic  ren;
    logic  wen;
    word_t addr;
    word_t wdata;
    word_t rdata;
    logic  hit;

    modport requester (output ren, wen, addr, wdata, input rdata, hit);
    modport server (input ren, wen, addr, wdata, output rdata, hit);
endinterface

`default_nettype wire

// File: src/cpu_types_pkg.sv
/*
  Types for the pipelined core. The encodings follow the MIPS subset.
  HALT is the all-ones opcode.
*/
`default_nettype none
`include "cpu_settings.svh"

package cpu_types_pkg;

    typedef logic [`CPU_WORD_W-1:0] word_t;
    typedef logic [$clog2(`CPU_REG_COUNT)-1:0] regbits_t;

    typedef enum logic [5:0] {
        RTYPE = 6'h00,
        J     = 6'h02,
        JAL   = 6'h03,
        BEQ   = 6'h04,
        BNE   = 6'h05,
        ADDIU = 6'h09,
        ORI   = 6'h0d,
        LUI   = 6'h0f,
        LW    = 6'h23,
        SW    = 6'h2b,
        HALT  = 6'h3f
    } opcode_t;

    typedef enum logic [5:0] {
        FN_SLLV = 6'h04,
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } funct_t;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_SLL, ALU_LUI
    } alu_op_t;

    typedef enum logic [1:0] {ARB_IDLE, ARB_HOST, ARB_DATA, ARB_FETCH} arb_state_t;

    // Destination register: rt, rd or the link register
    typedef enum logic [1:0] {REG_DST_RT, REG_DST_RD, REG_DST_RA} regdst_t;

    typedef struct packed {
        alu_op_t alu_op;
        logic    alu_src;
        logic    zero_ext;
        regdst_t reg_dst;
        logic    reg_wen;
        logic    mem_ren;
        logic    mem_wen;
        logic    mem_to_reg;
        logic    beq;
        logic    bne;
        logic    jump;
        logic    jal;
        logic    jr;
        logic    halt;
    } ctrl_t;

endpackage

`default_nettype wire

// File: src/cpu_settings.svh
/*
  Core sizing and timing constants shared by the package and the RTL.
  CPU_RAM_LATENCY must be at least 1. CPU_MEM_WORDS must be a power of two.
*/
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

`define CPU_WORD_W      32
`define CPU_REG_COUNT   32
`define CPU_MEM_WORDS   256
`define CPU_PC_INIT     32'h0000_0000
`define CPU_RAM_LATENCY 2

`endif
